/* verilog/cache_pkg.sv */
// cache package with the line geometry, the controller states and the burst RAM command
package cache_pkg;

  // bits selecting a 32-bit word within a cache line
  localparam int column_ix_width = 3;

  // word aligned addresses, the two low bits are ignored
  localparam int zeros_width = 2;

  localparam int column_count = 2 ** column_ix_width;

  // two words travel in each 64-bit beat
  localparam int beat_count = column_count / 2;

  typedef enum logic [3:0] {
    idle,
    read_wait,
    read_beat1,
    read_beat2,
    read_beat3,
    read_update_tag,
    read_finish,
    write_beat1,
    write_beat2,
    write_beat3,
    write_finish
  } cache_state_e;

  // command driven with the br_cmd_en strobe
  typedef enum logic {
    cmd_read  = 1'b0,
    cmd_write = 1'b1
  } ram_cmd_e;

endpackage

/* verilog/bram.sv */
// single-port 32-bit block RAM with byte write enables and a registered read
`timescale 1ns/100ps

module bram #(
  parameter int address_width = 8
) (
  input  logic                     clk,
  input  logic [3:0]               write_enable,
  input  logic [address_width-1:0] address,
  input  logic [31:0]              data_in,
  output logic [31:0]              data_out
);

  logic [31:0] mem [2 ** address_width];

  // all zero at start so every tag begins invalid and clean
  initial begin
    for (int i = 0; i < 2 ** address_width; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (write_enable[b]) begin
        mem[address][8*b +: 8] <= data_in[8*b +: 8];
      end
    end
    // read returns the word as it was before a write in the same cycle
    data_out <= mem[address];
  end

endmodule

/* verilog/cache.sv */
// direct-mapped write-back data cache between a 32-bit client port and a 64-bit burst RAM
`timescale 1ns/100ps

module cache
  import cache_pkg::*;
#(
  parameter int line_index_width     = 8,
  parameter int ram_address_width    = 21,
  parameter int command_delay_cycles = 13
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         enable,
  input  logic [31:0]                  address,
  input  logic [31:0]                  data_in,
  input  logic [3:0]                   write_enable,
  output logic [31:0]                  data_out,
  output logic                         data_out_ready,
  output logic                         busy,
  output ram_cmd_e                     br_cmd,
  output logic                         br_cmd_en,
  output logic [ram_address_width-1:0] br_addr,
  output logic [63:0]                  br_wr_data,
  input  logic [63:0]                  br_rd_data,
  input  logic                         br_rd_data_valid
);

  localparam int line_shift  = column_ix_width + zeros_width;
  localparam int tag_width   = 32 - line_index_width - line_shift;
  // tag word layout is {zeros, dirty, valid, tag}
  localparam int pad_width   = 32 - tag_width - 2;
  localparam int count_width = $clog2(command_delay_cycles + 1);

  cache_state_e state;

  // address split |tag|line|column|00|
  logic [column_ix_width-1:0]  column_ix;
  logic [line_index_width-1:0] line_ix;
  logic [tag_width-1:0]        address_tag;

  assign column_ix   = address[zeros_width +: column_ix_width];
  assign line_ix     = address[line_shift +: line_index_width];
  assign address_tag = address[31 -: tag_width];

  // line start addresses in RAM, for the fill and for the eviction
  logic [31:0]          fill_line_address;
  logic [31:0]          evict_line_address;
  logic [tag_width-1:0] cached_tag;
  logic                 line_valid;
  logic                 line_dirty;

  assign fill_line_address  = {address[31:line_shift], {line_shift{1'b0}}};
  assign evict_line_address = {cached_tag, line_ix, {line_shift{1'b0}}};

  logic [3:0]  tag_write_enable;
  logic [31:0] tag_data_in;
  logic [31:0] tag_data_out;

  bram #(
    .address_width(line_index_width)
  ) tag_ram (
    .clk         (clk),
    .write_enable(tag_write_enable),
    .address     (line_ix),
    .data_in     (tag_data_in),
    .data_out    (tag_data_out)
  );

  assign cached_tag = tag_data_out[tag_width-1:0];
  assign line_valid = tag_data_out[tag_width];
  assign line_dirty = tag_data_out[tag_width+1];

  logic [31:0] column_data_out     [column_count];
  logic [31:0] column_data_in      [column_count];
  logic [3:0]  column_write_enable [column_count];

  for (genvar i = 0; i < column_count; i++) begin : g_column
    bram #(
      .address_width(line_index_width)
    ) column_ram (
      .clk         (clk),
      .write_enable(column_write_enable[i]),
      .address     (line_ix),
      .data_in     (column_data_in[i]),
      .data_out    (column_data_out[i])
    );
  end

  // RAM outputs belong to the line addressed one cycle earlier
  logic [line_index_width-1:0] read_line_q;
  logic                        read_valid_q;
  logic                        tag_current;
  logic                        tag_match;
  logic                        hit;
  logic                        miss;

  assign tag_current = read_valid_q && read_line_q == line_ix;
  assign tag_match   = line_valid && cached_tag == address_tag;
  assign hit         = enable && tag_current && tag_match;
  assign miss        = enable && tag_current && !tag_match;

  logic [count_width-1:0] command_count;

  assign busy = (enable && !hit) || command_count != '0 || state != idle;

  assign data_out       = column_data_out[column_ix];
  assign data_out_ready = hit && write_enable == 4'b0000;

  // beat number of the fill or eviction in progress
  logic                       fill_beat;
  logic [column_ix_width-2:0] beat_ix;

  always_comb begin
    fill_beat = 1'b0;
    beat_ix   = '0;
    case (state)
      read_wait: fill_beat = br_rd_data_valid;
      read_beat1: begin
        fill_beat = 1'b1;
        beat_ix   = 2'd1;
      end
      read_beat2: begin
        fill_beat = 1'b1;
        beat_ix   = 2'd2;
      end
      read_beat3: begin
        fill_beat = 1'b1;
        beat_ix   = 2'd3;
      end
      write_beat1: beat_ix = 2'd1;
      write_beat2: beat_ix = 2'd2;
      write_beat3: beat_ix = 2'd3;
      default: beat_ix = '0;
    endcase
  end

  always_comb begin
    tag_write_enable = 4'b0000;
    // a fresh line is valid and clean
    tag_data_in = {{pad_width{1'b0}}, 1'b0, 1'b1, address_tag};
    for (int i = 0; i < column_count; i++) begin
      column_write_enable[i] = 4'b0000;
      column_data_in[i]      = data_in;
      if (fill_beat) begin
        // even columns take the low half of the beat
        column_data_in[i] = br_rd_data[32*(i%2) +: 32];
        if (i / 2 == int'(beat_ix)) begin
          column_write_enable[i] = 4'b1111;
        end
      end
    end

    if (state == read_update_tag) begin
      tag_write_enable = 4'b1111;
    end else if (state == idle && hit && write_enable != 4'b0000) begin
      // write hit, store the enabled bytes and mark the line dirty
      tag_write_enable               = 4'b1111;
      tag_data_in                    = {{pad_width{1'b0}}, 1'b1, 1'b1, address_tag};
      column_write_enable[column_ix] = write_enable;
    end
  end

  // eviction beat from the two columns of the current beat number
  always_ff @(posedge clk) begin
    br_wr_data <= {column_data_out[{beat_ix, 1'b1}], column_data_out[{beat_ix, 1'b0}]};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= idle;
      command_count <= '0;
      br_cmd        <= cmd_read;
      br_cmd_en     <= 1'b0;
      br_addr       <= '0;
      read_line_q   <= '0;
      read_valid_q  <= 1'b0;
    end else begin
      read_line_q  <= line_ix;
      read_valid_q <= 1'b1;
      br_cmd_en    <= 1'b0;
      if (command_count != '0) begin
        command_count <= command_count - 1'b1;
      end

      case (state)
        idle: begin
          if (miss && command_count == '0) begin
            br_cmd_en     <= 1'b1;
            command_count <= count_width'(command_delay_cycles);
            if (line_dirty) begin
              // write the old line back first
              br_cmd  <= cmd_write;
              br_addr <= evict_line_address[ram_address_width-1:0];
              state   <= write_beat1;
            end else begin
              br_cmd  <= cmd_read;
              br_addr <= fill_line_address[ram_address_width-1:0];
              state   <= read_wait;
            end
          end
        end
        read_wait: begin
          if (br_rd_data_valid) begin
            state <= read_beat1;
          end
        end
        read_beat1: state <= read_beat2;
        read_beat2: state <= read_beat3;
        read_beat3: state <= read_update_tag;
        read_update_tag: state <= read_finish;
        // new tag is read back here before busy can fall
        read_finish: state <= idle;
        write_beat1: state <= write_beat2;
        write_beat2: state <= write_beat3;
        write_beat3: state <= write_finish;
        write_finish: begin
          if (command_count == '0) begin
            br_cmd        <= cmd_read;
            br_cmd_en     <= 1'b1;
            br_addr       <= fill_line_address[ram_address_width-1:0];
            command_count <= count_width'(command_delay_cycles);
            state         <= read_wait;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

/* verilog/burst_ram.sv */
// behavioral 64-bit burst RAM, four beats per command with a fixed read latency
`timescale 1ns/100ps

module burst_ram
  import cache_pkg::*;
#(
  parameter int ram_address_width = 21,
  parameter int read_latency      = 6
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  ram_cmd_e                     cmd,
  input  logic                         cmd_en,
  input  logic [ram_address_width-1:0] addr,
  input  logic [63:0]                  wr_data,
  output logic [63:0]                  rd_data,
  output logic                         rd_data_valid
);

  // at most 32 KB of memory is modeled
  localparam int index_width = (ram_address_width - 3 < 12) ? ram_address_width - 3 : 12;
  localparam int word_count  = 2 ** index_width;
  localparam int wait_width  = $clog2(read_latency + 1);

  logic [63:0] mem [word_count];

  logic [index_width-1:0] cmd_index;
  assign cmd_index = addr[3 +: index_width];

  // write burst
  logic [1:0]             wr_left;
  logic [index_width-1:0] wr_index;

  // read burst
  logic                   rd_active;
  logic [wait_width-1:0]  rd_wait;
  logic [1:0]             rd_beat;
  logic [index_width-1:0] rd_base;

  // every 32-bit word holds its own byte address
  initial begin
    for (int i = 0; i < word_count; i++) begin
      mem[i] = {32'(i * 8 + 4), 32'(i * 8)};
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_en && cmd == cmd_write) begin
      mem[cmd_index] <= wr_data;
    end else if (wr_left != 2'd0) begin
      mem[wr_index] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_left   <= 2'd0;
      wr_index  <= '0;
      rd_active <= 1'b0;
      rd_wait   <= '0;
      rd_beat   <= 2'd0;
      rd_base   <= '0;
    end else begin
      // beat 0 came with the strobe, three more follow
      if (cmd_en && cmd == cmd_write) begin
        wr_left  <= 2'(beat_count - 1);
        wr_index <= cmd_index + 1'b1;
      end else if (wr_left != 2'd0) begin
        wr_left  <= wr_left - 1'b1;
        wr_index <= wr_index + 1'b1;
      end

      if (cmd_en && cmd == cmd_read) begin
        rd_active <= 1'b1;
        rd_wait   <= wait_width'(read_latency - 1);
        rd_beat   <= 2'd0;
        rd_base   <= cmd_index;
      end else if (rd_active) begin
        if (rd_wait != '0) begin
          rd_wait <= rd_wait - 1'b1;
        end else begin
          rd_beat <= rd_beat + 1'b1;
          if (rd_beat == 2'(beat_count - 1)) begin
            rd_active <= 1'b0;
          end
        end
      end
    end
  end

  assign rd_data_valid = rd_active && rd_wait == '0;
  assign rd_data       = mem[rd_base + index_width'(rd_beat)];

endmodule

/* verilog/cache_top.sv */
// cache top level joining the cache controller to the behavioral burst RAM
`timescale 1ns/100ps

module cache_top
  import cache_pkg::*;
#(
  parameter int line_index_width     = 8,
  parameter int ram_address_width    = 21,
  parameter int command_delay_cycles = 13,
  parameter int read_latency         = 6
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  logic [31:0] address,
  input  logic [31:0] data_in,
  input  logic [3:0]  write_enable,
  output logic [31:0] data_out,
  output logic        data_out_ready,
  output logic        busy
);

  ram_cmd_e                     br_cmd;
  logic                         br_cmd_en;
  logic [ram_address_width-1:0] br_addr;
  logic [63:0]                  br_wr_data;
  logic [63:0]                  br_rd_data;
  logic                         br_rd_data_valid;

  cache #(
    .line_index_width    (line_index_width),
    .ram_address_width   (ram_address_width),
    .command_delay_cycles(command_delay_cycles)
  ) cache0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable          (enable),
    .address         (address),
    .data_in         (data_in),
    .write_enable    (write_enable),
    .data_out        (data_out),
    .data_out_ready  (data_out_ready),
    .busy            (busy),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

  burst_ram #(
    .ram_address_width(ram_address_width),
    .read_latency     (read_latency)
  ) ram0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd          (br_cmd),
    .cmd_en       (br_cmd_en),
    .addr         (br_addr),
    .wr_data      (br_wr_data),
    .rd_data      (br_rd_data),
    .rd_data_valid(br_rd_data_valid)
  );

endmodule

/* sim/tb_clock.sv */
// testbench clock and reset generator for the cache testbench
`timescale 1ns/100ps

module tb_clock #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // reset released on a rising edge after a fixed number of cycles
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* sim/cache_checker.sv */
// cache client port checker for read data, busy, data_out_ready and RAM command spacing
`timescale 1ns/100ps

module cache_checker #(
  parameter int command_delay_cycles = 13
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [3:0]  write_enable,
  input  logic [31:0] data_out,
  input  logic        data_out_ready,
  input  logic        busy,
  input  logic        cmd_strobe,
  output int          check_count,
  output int          error_count
);

  // request in progress as set by the testbench top
  string       test_name;
  logic        active;
  logic        is_write;
  logic        expect_hit;
  logic [31:0] expected;
  logic        busy_seen;

  logic        strobe_seen;
  int          strobe_gap;

  initial begin
    test_name   = "none";
    active      = 1'b0;
    is_write    = 1'b0;
    expect_hit  = 1'b0;
    expected    = '0;
    busy_seen   = 1'b0;
    strobe_seen = 1'b0;
    strobe_gap  = 0;
    check_count = 0;
    error_count = 0;
  end

  // a request that should miss must have raised busy at least once
  task automatic close_request();
    if (active && !expect_hit && !busy_seen) begin
      $display("ERROR: busy never went high in %s although the request should miss",
               test_name);
      error_count++;
    end
    busy_seen = 1'b0;
  endtask

  task automatic start_request(input string name, input logic write_op, input logic hit_op,
                               input logic [31:0] value);
    close_request();
    test_name  = name;
    is_write   = write_op;
    expect_hit = hit_op;
    expected   = value;
    active     = 1'b1;
  endtask

  task automatic stop_requests();
    close_request();
    active = 1'b0;
  endtask

  // sampled mid-cycle, away from the edge where inputs change
  always @(negedge clk) begin
    if (rst_n) begin
      if (data_out_ready && write_enable != 4'b0000) begin
        $display("ERROR: data_out_ready high with write_enable %h in %s",
                 write_enable, test_name);
        error_count++;
      end

      if (active && busy) begin
        busy_seen = 1'b1;
      end

      if (active && !is_write) begin
        if (data_out_ready) begin
          check_count++;
          if (data_out !== expected) begin
            $display("CHECK FAILED %s: expected %08h, actual %08h",
                     test_name, expected, data_out);
            error_count++;
          end
        end else if (!busy) begin
          // busy low on a read means a hit, so data must be ready
          $display("ERROR: busy low but data_out_ready low in %s", test_name);
          error_count++;
        end
      end

      if (active && expect_hit && busy) begin
        $display("ERROR: busy went high in %s although the request should hit", test_name);
        error_count++;
      end

      // cycles since the previous RAM command
      if (strobe_seen) begin
        strobe_gap++;
      end
      if (cmd_strobe) begin
        if (strobe_seen && strobe_gap < command_delay_cycles) begin
          $display("ERROR: RAM commands only %0d cycles apart, at least %0d needed, in %s",
                   strobe_gap, command_delay_cycles, test_name);
          error_count++;
        end
        strobe_seen = 1'b1;
        strobe_gap  = 0;
      end
    end
  end

endmodule

/* sim/tb_cache.sv */
// testbench top for the cache that reads the request list and drives the client port
`timescale 1ns/100ps

module tb_cache;

  localparam int line_index_width     = 2;
  localparam int command_delay_cycles = 13;
  localparam int busy_timeout         = 200;
  localparam int reset_timeout        = 100;

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [3:0]  write_enable;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;
  int          check_count;
  int          error_count;
  int          failure_count;
  int          request_count;

  tb_clock #(
    .period_ns   (8),
    .reset_cycles(16)
  ) clock0 (
    .clk  (clk),
    .rst_n(rst_n)
  );

  cache_top #(
    .line_index_width    (line_index_width),
    .command_delay_cycles(command_delay_cycles)
  ) dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .address       (address),
    .data_in       (data_in),
    .write_enable  (write_enable),
    .data_out      (data_out),
    .data_out_ready(data_out_ready),
    .busy          (busy)
  );

  cache_checker #(
    .command_delay_cycles(command_delay_cycles)
  ) checker0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .write_enable  (write_enable),
    .data_out      (data_out),
    .data_out_ready(data_out_ready),
    .busy          (busy),
    .cmd_strobe    (dut0.br_cmd_en),
    .check_count   (check_count),
    .error_count   (error_count)
  );

  function automatic string group_name(input int group);
    case (group)
      1: return "cold_miss";
      2: return "read_hit";
      3: return "masked_write";
      4: return "dirty_evict";
      5: return "clean_conflict";
      default: return "unknown";
    endcase
  endfunction

  // called on a rising edge and returns on the rising edge after the hold cycle
  task automatic run_request(input string name, input logic write_op, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be,
                             input logic [31:0] value, input logic hit_op,
                             output logic timed_out);
    int cycles;
    cycles    = 0;
    timed_out = 1'b0;
    checker0.start_request(name, write_op, hit_op, value);
    enable       <= 1'b1;
    address      <= addr;
    data_in      <= write_op ? wdata : 32'h0;
    write_enable <= write_op ? be : 4'h0;
    @(negedge clk);
    while (busy && cycles < busy_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (busy) begin
      $display("timeout: busy still high after %0d cycles in %s", busy_timeout, name);
      timed_out = 1'b1;
    end else begin
      // the busy-low cycle ends here and the inputs stay for one more cycle
      @(posedge clk);
    end
    @(posedge clk);
  endtask

  initial begin
    int               fd;
    int               fields;
    int               group;
    int               op;
    int               hit;
    int               cycles;
    logic [31:0]      addr;
    logic [31:0]      wdata;
    logic [31:0]      be_word;
    logic [31:0]      value;
    logic [8*128-1:0] text;
    logic             timed_out;
    logic             stop;

    enable        = 1'b0;
    address       = '0;
    data_in       = '0;
    write_enable  = 4'h0;
    failure_count = 0;
    request_count = 0;
    stop          = 1'b0;
    cycles        = 0;

    @(negedge clk);
    while (!rst_n && cycles < reset_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!rst_n) begin
      $display("timeout: reset was never released");
      failure_count++;
      stop = 1'b1;
    end
    @(posedge clk);

    fd = $fopen("sim/cache_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/cache_stimulus.txt");
      failure_count++;
    end

    while (fd != 0 && !stop) begin
      text = '0;
      if ($fgets(text, fd) == 0) begin
        stop = 1'b1;
      end else begin
        // comment and blank lines do not scan
        fields = $sscanf(text, "%h %h %h %h %h %h %h",
                         group, op, addr, wdata, be_word, value, hit);
        if (fields == 7) begin
          request_count++;
          run_request($sformatf("%s_%0d", group_name(group), request_count), op != 0,
                      addr, wdata, be_word[3:0], value, hit != 0, timed_out);
          if (timed_out) begin
            failure_count++;
            stop = 1'b1;
          end
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (request_count == 0) begin
      $display("no requests were read from the stimulus file");
      failure_count++;
    end

    checker0.stop_requests();
    enable       <= 1'b0;
    write_enable <= 4'h0;
    @(posedge clk);

    $display("requests %0d, read checks %0d, checker errors %0d, testbench failures %0d",
             request_count, check_count, error_count, failure_count);
    if (error_count == 0 && failure_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* sim/cache_stimulus.txt */
# group op address write_data byte_enables expected hit, all in hex, one request per line
# group 1 cold_miss 2 read_hit 3 masked_write 4 dirty_evict 5 clean_conflict, op 1 write, hit 1 busy stays low
1 0 00000104 00000000 0 00000104 0
1 0 000002a8 00000000 0 000002a8 0
1 0 00007ffc 00000000 0 00007ffc 0
1 0 00001c5c 00000000 0 00001c5c 0
2 0 00001c40 00000000 0 00001c40 1
2 0 00001c44 00000000 0 00001c44 1
2 0 00001c58 00000000 0 00001c58 1
3 1 00001c48 aabbccdd 3 00000000 1
3 0 00001c48 00000000 0 0000ccdd 1
3 1 00001c4c 11223344 c 00000000 1
3 0 00001c4c 00000000 0 11221c4c 1
3 1 00001c50 deadbeef 5 00000000 1
3 0 00001c50 00000000 0 00ad1cef 1
4 0 00001cc8 00000000 0 00001cc8 0
4 0 00001c48 00000000 0 0000ccdd 0
4 0 00001c4c 00000000 0 11221c4c 1
4 0 00001c50 00000000 0 00ad1cef 1
4 0 00001c5c 00000000 0 00001c5c 1
4 1 000006a4 12345678 f 00000000 0
4 0 000006a4 00000000 0 12345678 1
4 0 000002a8 00000000 0 000002a8 0
4 0 000006a4 00000000 0 12345678 0
4 0 000006a0 00000000 0 000006a0 1
5 0 00000064 00000000 0 00000064 0
5 0 000000e8 00000000 0 000000e8 0
5 0 00000070 00000000 0 00000070 0
5 0 000000f4 00000000 0 000000f4 0
5 0 00003fe4 00000000 0 00003fe4 0
5 0 0000007c 00000000 0 0000007c 0

/* all.f */
verilog/cache_pkg.sv
verilog/bram.sv
verilog/cache.sv
verilog/burst_ram.sv
verilog/cache_top.sv
sim/tb_clock.sv
sim/cache_checker.sv
sim/tb_cache.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_cache -f all.f
output=$(./obj_dir/Vtb_cache)
echo "$output"
echo "$output" | grep -q "All tests passed"
